//--- src/soc_defs.svh
// board control definitions
// bus widths, op codes, address map, device ids and reset counter size
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

`define SOC_ARCHBITSZ 32
`define SOC_ADDRBITSZ 30
`define SOC_GPIOCOUNT 8
`define SOC_RST_CNTR_BITSZ 4

// bus op codes, read-write (3) is treated as nop
`define PI1_OP_NOP 2'd0
`define PI1_OP_WRITE 2'd1
`define PI1_OP_READ 2'd2

// word address map
`define SOC_DEVTBL_BASE 30'd0
`define SOC_DEVTBL_WORDS 30'd16
`define SOC_GPIO_BASE 30'd16
`define SOC_GPIO_WORDS 30'd4
`define SOC_RSTCMD_WORD 30'd15

// decoder slots
`define SOC_SLOT_DEVTBL 2'd0
`define SOC_SLOT_GPIO 2'd1
`define SOC_SLOT_INVALID 2'd2

`define SOC_DEVID_DEVTBL 16'd7
`define SOC_DEVID_GPIO 16'd6
`define SOC_DEVID_INVALID 16'd0
`define SOC_INVALID_MAPSZ 32'd4096

`endif

//--- src/soc_bus_pkg.sv
// bus package
// vector types carried on the peripheral bus and the gpio pins
`include "soc_defs.svh"

package soc_bus_pkg;

	// one bus data word
	typedef logic [`SOC_ARCHBITSZ-1:0] word_t;

	// word address, byte offset bits dropped
	typedef logic [`SOC_ADDRBITSZ-1:0] word_addr_t;

	// one select bit per data byte
	typedef logic [(`SOC_ARCHBITSZ/8)-1:0] byte_sel_t;

	// nop, write, read
	typedef logic [1:0] pi1_op_t;

	typedef logic [`SOC_GPIOCOUNT-1:0] gpio_t;

endpackage

//--- src/soc_ctrl_pkg.sv
// control package
// decoder slot, device id and reset sequencer state types
`include "soc_defs.svh"

package soc_ctrl_pkg;

	// decoder slot, see the SOC_SLOT_* codes
	typedef logic [1:0] slot_idx_t;

	// id field of a device table entry
	typedef logic [15:0] dev_id_t;

	// reset sequencer states
	typedef enum logic [1:0] {
		// counter running, system held in reset
		RS_HOLD,
		RS_RUN,
		// powered off until the board reset
		RS_OFF
	} reset_state_t;

endpackage

//--- src/reset_seq.sv
// reset sequencer
// stretches the board reset with a down counter, restarts it on a software
// warm reset request and latches a software power-off until the board reset
`timescale 1ns/1ps
`include "soc_defs.svh"

module reset_seq (
	input  logic clk200mhz_w,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);

	soc_ctrl_pkg::reset_state_t state_q;
	logic [`SOC_RST_CNTR_BITSZ-1:0] cntr_q;
	logic warm_w;
	logic pwroff_w;

	// both levels high also counts as warm reset
	assign warm_w = rst1_i;
	assign pwroff_w = rst0_i & ~rst1_i;

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			state_q <= soc_ctrl_pkg::RS_HOLD;
			cntr_q <= '1;
		end else begin
			case (state_q)
				soc_ctrl_pkg::RS_OFF: begin
					// only the board reset leaves this state
					state_q <= soc_ctrl_pkg::RS_OFF;
				end
				default: begin
					if (pwroff_w) begin
						state_q <= soc_ctrl_pkg::RS_OFF;
					end else if (warm_w) begin
						state_q <= soc_ctrl_pkg::RS_HOLD;
						cntr_q <= '1;
					end else if (state_q == soc_ctrl_pkg::RS_HOLD) begin
						cntr_q <= cntr_q - 1'b1;
						// release on the edge where the count hits zero
						if (cntr_q == `SOC_RST_CNTR_BITSZ'(1))
							state_q <= soc_ctrl_pkg::RS_RUN;
					end
				end
			endcase
		end
	end

	assign sys_rst_o = (state_q != soc_ctrl_pkg::RS_RUN);

endmodule

//--- src/pi1_decoder.sv
// bus address decoder
// steers accepted ops to the device table or gpio, returns read data one
// cycle later and answers unmapped addresses with zero data
`timescale 1ns/1ps
`include "soc_defs.svh"

module pi1_decoder (
	input  logic                    clk200mhz_w,
	input  logic                    sys_rst_i,
	input  soc_bus_pkg::pi1_op_t    op_i,
	input  soc_bus_pkg::word_addr_t addr_i,
	input  soc_bus_pkg::word_t      data_i,
	input  soc_bus_pkg::byte_sel_t  sel_i,
	output soc_bus_pkg::word_t      data_o,
	output logic                    rdy_o,
	output soc_bus_pkg::pi1_op_t    tbl_op_o,
	output soc_bus_pkg::pi1_op_t    gpio_op_o,
	output soc_bus_pkg::word_addr_t offs_o,
	output soc_bus_pkg::word_t      wdata_o,
	output soc_bus_pkg::byte_sel_t  sel_o,
	input  soc_bus_pkg::word_t      tbl_data_i,
	input  soc_bus_pkg::word_t      gpio_data_i
);

	soc_ctrl_pkg::slot_idx_t slot_w;
	soc_ctrl_pkg::slot_idx_t rd_slot_q;
	logic rd_vld_q;
	logic accept_w;

	// slaves never stall, so the bus is ready whenever the system runs
	assign rdy_o = ~sys_rst_i;
	assign accept_w = rdy_o & ((op_i == `PI1_OP_WRITE) | (op_i == `PI1_OP_READ));

	// subtraction wraps below a base, so one compare per window is enough
	always_comb begin
		if ((addr_i - `SOC_DEVTBL_BASE) < `SOC_DEVTBL_WORDS) begin
			slot_w = `SOC_SLOT_DEVTBL;
			offs_o = addr_i - `SOC_DEVTBL_BASE;
		end else if ((addr_i - `SOC_GPIO_BASE) < `SOC_GPIO_WORDS) begin
			slot_w = `SOC_SLOT_GPIO;
			offs_o = addr_i - `SOC_GPIO_BASE;
		end else begin
			slot_w = `SOC_SLOT_INVALID;
			offs_o = addr_i;
		end
	end

	assign tbl_op_o = (accept_w && slot_w == `SOC_SLOT_DEVTBL) ? op_i : `PI1_OP_NOP;
	assign gpio_op_o = (accept_w && slot_w == `SOC_SLOT_GPIO) ? op_i : `PI1_OP_NOP;
	assign wdata_o = data_i;
	assign sel_o = sel_i;

	// remember which slave owes read data next cycle
	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i)
			rd_vld_q <= 1'b0;
		else
			rd_vld_q <= accept_w & (op_i == `PI1_OP_READ);
	end

	always_ff @(posedge clk200mhz_w) begin
		if (accept_w)
			rd_slot_q <= slot_w;
	end

	always_comb begin
		data_o = '0;
		if (rd_vld_q) begin
			case (rd_slot_q)
				`SOC_SLOT_DEVTBL: data_o = tbl_data_i;
				`SOC_SLOT_GPIO: data_o = gpio_data_i;
				// invalid device reads as zero
				default: data_o = '0;
			endcase
		end
	end

endmodule

//--- src/dev_table.sv
// device table
// read-only id, interrupt flag and map size per decoder slot, plus the
// software reset command register in the last word
`timescale 1ns/1ps
`include "soc_defs.svh"

module dev_table (
	input  logic                    clk200mhz_w,
	input  logic                    sys_rst_i,
	input  soc_bus_pkg::pi1_op_t    op_i,
	input  soc_bus_pkg::word_addr_t offs_i,
	input  soc_bus_pkg::word_t      data_i,
	input  soc_bus_pkg::byte_sel_t  sel_i,
	output soc_bus_pkg::word_t      data_o,
	output logic                    rst0_o,
	output logic                    rst1_o
);

	soc_ctrl_pkg::slot_idx_t slot_w;
	soc_ctrl_pkg::dev_id_t dev_id_w;
	soc_bus_pkg::word_t mapsz_w;
	soc_bus_pkg::word_t rd_word_w;
	logic useintr_w;

	// two words per slot, the entry index is the offset over two
	assign slot_w = soc_ctrl_pkg::slot_idx_t'(offs_i[2:1]);

	always_comb begin
		case (slot_w)
			`SOC_SLOT_DEVTBL: begin
				dev_id_w = `SOC_DEVID_DEVTBL;
				mapsz_w = {`SOC_DEVTBL_WORDS, 2'b00};
				useintr_w = 1'b0;
			end
			`SOC_SLOT_GPIO: begin
				dev_id_w = `SOC_DEVID_GPIO;
				mapsz_w = {`SOC_GPIO_WORDS, 2'b00};
				useintr_w = 1'b1;
			end
			default: begin
				dev_id_w = `SOC_DEVID_INVALID;
				mapsz_w = `SOC_INVALID_MAPSZ;
				useintr_w = 1'b0;
			end
		endcase
	end

	always_comb begin
		rd_word_w = '0;
		if (offs_i < soc_bus_pkg::word_addr_t'(2 * (`SOC_SLOT_INVALID + 1))) begin
			if (offs_i[0])
				rd_word_w = mapsz_w;
			else
				rd_word_w = {useintr_w, {(`SOC_ARCHBITSZ-17){1'b0}}, dev_id_w};
		end
	end

	always_ff @(posedge clk200mhz_w) begin
		if (op_i == `PI1_OP_READ)
			data_o <= rd_word_w;
	end

	// reset command, cleared again by the system reset it causes
	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (op_i == `PI1_OP_WRITE && offs_i == `SOC_RSTCMD_WORD && sel_i[0]) begin
			rst0_o <= data_i[0];
			rst1_o <= data_i[1];
		end
	end

endmodule

//--- src/gpio_port.sv
// gpio port
// output register and double-synchronized input pins on the bus
`timescale 1ns/1ps
`include "soc_defs.svh"

module gpio_port (
	input  logic                    clk200mhz_w,
	input  logic                    sys_rst_i,
	input  soc_bus_pkg::pi1_op_t    op_i,
	input  soc_bus_pkg::word_addr_t offs_i,
	input  soc_bus_pkg::word_t      data_i,
	input  soc_bus_pkg::byte_sel_t  sel_i,
	output soc_bus_pkg::word_t      data_o,
	input  soc_bus_pkg::gpio_t      gp_i,
	output soc_bus_pkg::gpio_t      gp_o
);

	soc_bus_pkg::gpio_t sync0_q;
	soc_bus_pkg::gpio_t sync1_q;
	soc_bus_pkg::gpio_t out_q;

	// pins are asynchronous to the bus clock
	always_ff @(posedge clk200mhz_w) begin
		sync0_q <= gp_i;
		sync1_q <= sync0_q;
	end

	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i)
			out_q <= '0;
		else if (op_i == `PI1_OP_WRITE && offs_i == 30'd1 && sel_i[0])
			out_q <= data_i[`SOC_GPIOCOUNT-1:0];
	end

	always_ff @(posedge clk200mhz_w) begin
		if (op_i == `PI1_OP_READ) begin
			case (offs_i)
				30'd0: data_o <= soc_bus_pkg::word_t'(sync1_q);
				30'd1: data_o <= soc_bus_pkg::word_t'(out_q);
				default: data_o <= '0;
			endcase
		end
	end

	assign gp_o = out_q;

endmodule

//--- src/soc_top.sv
// board control top level
// reset sequencer, bus decoder, device table and gpio on one clock
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top (
	input  logic                    clk200mhz_w,
	input  logic                    rst_p,
	input  soc_bus_pkg::pi1_op_t    op_i,
	input  soc_bus_pkg::word_addr_t addr_i,
	input  soc_bus_pkg::word_t      data_i,
	input  soc_bus_pkg::byte_sel_t  sel_i,
	output soc_bus_pkg::word_t      data_o,
	output logic                    rdy_o,
	input  soc_bus_pkg::gpio_t      gp_i,
	output soc_bus_pkg::gpio_t      gp_o,
	output logic                    sys_rst_o
);

	logic rst0_w;
	logic rst1_w;
	soc_bus_pkg::pi1_op_t tbl_op_w;
	soc_bus_pkg::pi1_op_t gpio_op_w;
	soc_bus_pkg::word_addr_t offs_w;
	soc_bus_pkg::word_t wdata_w;
	soc_bus_pkg::byte_sel_t sel_w;
	soc_bus_pkg::word_t tbl_data_w;
	soc_bus_pkg::word_t gpio_data_w;

	reset_seq u_reset_seq (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.rst0_i      (rst0_w),
		.rst1_i      (rst1_w),
		.sys_rst_o   (sys_rst_o)
	);

	pi1_decoder u_pi1_decoder (
		.clk200mhz_w (clk200mhz_w),
		.sys_rst_i   (sys_rst_o),
		.op_i        (op_i),
		.addr_i      (addr_i),
		.data_i      (data_i),
		.sel_i       (sel_i),
		.data_o      (data_o),
		.rdy_o       (rdy_o),
		.tbl_op_o    (tbl_op_w),
		.gpio_op_o   (gpio_op_w),
		.offs_o      (offs_w),
		.wdata_o     (wdata_w),
		.sel_o       (sel_w),
		.tbl_data_i  (tbl_data_w),
		.gpio_data_i (gpio_data_w)
	);

	dev_table u_dev_table (
		.clk200mhz_w (clk200mhz_w),
		.sys_rst_i   (sys_rst_o),
		.op_i        (tbl_op_w),
		.offs_i      (offs_w),
		.data_i      (wdata_w),
		.sel_i       (sel_w),
		.data_o      (tbl_data_w),
		.rst0_o      (rst0_w),
		.rst1_o      (rst1_w)
	);

	gpio_port u_gpio_port (
		.clk200mhz_w (clk200mhz_w),
		.sys_rst_i   (sys_rst_o),
		.op_i        (gpio_op_w),
		.offs_i      (offs_w),
		.data_i      (wdata_w),
		.sel_i       (sel_w),
		.data_o      (gpio_data_w),
		.gp_i        (gp_i),
		.gp_o        (gp_o)
	);

endmodule

//--- testbench/soc_properties.sv
// board control properties
// ready gating, gpio clearing and the power-off latch, bound into the top level
`timescale 1ns/1ps

module soc_properties (
	input logic               clk200mhz_w,
	input logic               rst_p,
	input logic               sys_rst_i,
	input logic               rdy_i,
	input soc_bus_pkg::gpio_t gp_out_i,
	input logic               rst0_i,
	input logic               rst1_i
);

	logic off_q;

	// follows the sequencer into power-off from the request levels
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p)
			off_q <= 1'b0;
		else if (rst0_i && !rst1_i)
			off_q <= 1'b1;
	end

	rdy_gated: assert property (@(posedge clk200mhz_w) sys_rst_i |-> !rdy_i)
		else $error("rdy_o high while sys_rst_o is high");

	// the output register clears on the first edge of the system reset
	gpio_cleared: assert property (@(posedge clk200mhz_w) sys_rst_i |=> (gp_out_i == '0))
		else $error("gp_o not cleared during system reset");

	off_held: assert property (@(posedge clk200mhz_w) off_q |-> sys_rst_i)
		else $error("sys_rst_o released in power-off before rst_p");

endmodule

bind soc_top soc_properties u_soc_properties (
	.clk200mhz_w (clk200mhz_w),
	.rst_p       (rst_p),
	.sys_rst_i   (sys_rst_o),
	.rdy_i       (rdy_o),
	.gp_out_i    (gp_o),
	.rst0_i      (rst0_w),
	.rst1_i      (rst1_w)
);

//--- testbench/tb_soc_top.sv
// testbench for the board control top level
// runs a table of bus ops through reset, warm reset and power-off sequences
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_top;

	logic clk200mhz_w;
	logic rst_p;
	soc_bus_pkg::pi1_op_t op;
	soc_bus_pkg::word_addr_t addr;
	soc_bus_pkg::word_t wdata;
	soc_bus_pkg::byte_sel_t sel;
	soc_bus_pkg::word_t rdata;
	logic rdy;
	soc_bus_pkg::gpio_t gp_in;
	soc_bus_pkg::gpio_t gp_out;
	logic sys_rst;

	// stimulus table, one op per entry
	string tbl_name[$];
	soc_bus_pkg::pi1_op_t tbl_op[$];
	soc_bus_pkg::word_addr_t tbl_addr[$];
	soc_bus_pkg::word_t tbl_wdata[$];
	soc_bus_pkg::byte_sel_t tbl_sel[$];
	soc_bus_pkg::word_t tbl_exp[$];
	bit tbl_chk[$];

	logic [15:0] lfsr_q;
	int mismatches;
	int failures;
	int cycle_cnt;
	int cycle_limit;

	soc_top dut (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.op_i        (op),
		.addr_i      (addr),
		.data_i      (wdata),
		.sel_i       (sel),
		.data_o      (rdata),
		.rdy_o       (rdy),
		.gp_i        (gp_in),
		.gp_o        (gp_out),
		.sys_rst_o   (sys_rst)
	);

	initial clk200mhz_w = 1'b0;
	always #4 clk200mhz_w = ~clk200mhz_w;

	always @(posedge clk200mhz_w) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("ERROR: timeout, the run did not end within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1, shifts toward the msb
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic lfsr_byte(output logic [7:0] b);
		int k;
		b = '0;
		for (k = 0; k < 8; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			b = {b[6:0], lfsr_q[15]};
		end
	endtask

	task automatic add_entry(input string name, input soc_bus_pkg::pi1_op_t op_v,
			input soc_bus_pkg::word_addr_t addr_v, input soc_bus_pkg::word_t wdata_v,
			input soc_bus_pkg::byte_sel_t sel_v, input soc_bus_pkg::word_t exp_v,
			input bit chk_v);
		tbl_name.push_back(name);
		tbl_op.push_back(op_v);
		tbl_addr.push_back(addr_v);
		tbl_wdata.push_back(wdata_v);
		tbl_sel.push_back(sel_v);
		tbl_exp.push_back(exp_v);
		tbl_chk.push_back(chk_v);
	endtask

	task automatic add_read(input string name, input soc_bus_pkg::word_addr_t addr_v,
			input soc_bus_pkg::word_t exp_v);
		add_entry(name, `PI1_OP_READ, addr_v, 32'h0, 4'hf, exp_v, 1'b1);
	endtask

	task automatic add_write(input string name, input soc_bus_pkg::word_addr_t addr_v,
			input soc_bus_pkg::word_t data_v, input soc_bus_pkg::byte_sel_t sel_v);
		add_entry(name, `PI1_OP_WRITE, addr_v, data_v, sel_v, 32'h0, 1'b0);
	endtask

	task automatic check_value(input string name, input soc_bus_pkg::word_t exp_v,
			input soc_bus_pkg::word_t act_v);
		if (act_v !== exp_v) begin
			$display("CHECK FAILED %s: expected 0x%08h actual 0x%08h", name, exp_v, act_v);
			mismatches++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR: %s", msg);
		failures++;
	endtask

	// ops pipeline one per cycle, read data is sampled one cycle after acceptance
	task automatic apply_entries(input int first, input int last);
		int idx;
		int pend_idx;
		bit pend;
		pend = 1'b0;
		pend_idx = 0;
		for (idx = first; idx <= last; idx++) begin
			@(negedge clk200mhz_w);
			if (pend)
				check_value(tbl_name[pend_idx], tbl_exp[pend_idx], rdata);
			op = tbl_op[idx];
			addr = tbl_addr[idx];
			wdata = tbl_wdata[idx];
			sel = tbl_sel[idx];
			// hold the op while the bus is not ready
			while (!rdy)
				@(negedge clk200mhz_w);
			pend = tbl_chk[idx] && (tbl_op[idx] == `PI1_OP_READ);
			pend_idx = idx;
		end
		@(negedge clk200mhz_w);
		if (pend)
			check_value(tbl_name[pend_idx], tbl_exp[pend_idx], rdata);
		op = `PI1_OP_NOP;
	endtask

	task automatic await_reset_rise(input string what);
		int n;
		n = 0;
		while (!sys_rst && n < 2) begin
			@(negedge clk200mhz_w);
			n++;
		end
		if (!sys_rst)
			note_failure($sformatf("sys_rst_o did not rise within 2 cycles of the %s", what));
	endtask

	task automatic await_reset_release(input string what);
		int n;
		bit rdy_bad;
		n = 0;
		rdy_bad = 1'b0;
		while (sys_rst && n < 17) begin
			if (rdy)
				rdy_bad = 1'b1;
			@(negedge clk200mhz_w);
			n++;
		end
		if (rdy_bad)
			note_failure($sformatf("rdy_o was high during the system reset after %s", what));
		if (sys_rst)
			note_failure($sformatf("sys_rst_o still high 17 cycles after %s", what));
	endtask

	initial begin
		logic [7:0] b_pre;
		logic [7:0] b_in;
		logic [7:0] b_out;
		int a_first;
		int b_first;
		int c_first;
		int d_first;
		int e_first;
		int f_first;
		bit off_ok;

		rst_p = 1'b1;
		op = `PI1_OP_NOP;
		addr = '0;
		wdata = '0;
		sel = '0;
		mismatches = 0;
		failures = 0;
		cycle_cnt = 0;
		lfsr_q = 16'd82;
		lfsr_byte(b_pre);
		lfsr_byte(b_out);
		lfsr_byte(b_in);
		gp_in = b_pre;

		a_first = tbl_name.size();
		// the read on the second edge still sees the old pin value
		add_read("gpio input before sync", 30'd16, {24'h0, b_pre});
		add_read("gpio input pins", 30'd16, {24'h0, b_in});
		add_read("devtbl word 0 id", 30'd0, 32'd7);
		add_read("devtbl word 1 size", 30'd1, 32'd64);
		add_read("devtbl word 2 gpio id", 30'd2, 32'h8000_0006);
		add_read("devtbl word 3 gpio size", 30'd3, 32'd16);
		add_read("devtbl word 4 invalid id", 30'd4, 32'd0);
		add_read("devtbl word 5 invalid size", 30'd5, 32'd4096);
		add_read("devtbl word 15 command", 30'd15, 32'd0);
		add_write("gpio output write", 30'd17, {24'h0, b_out}, 4'hf);
		add_read("gpio output readback", 30'd17, {24'h0, b_out});
		add_write("gpio write sel0 clear", 30'd17, {24'h0, ~b_out}, 4'he);
		add_read("gpio output after sel0 clear", 30'd17, {24'h0, b_out});

		b_first = tbl_name.size();
		add_read("unmapped read 20", 30'd20, 32'd0);
		add_read("unmapped read top", 30'h3fff_ffff, 32'd0);
		add_write("unmapped write 20", 30'd20, 32'hffff_ffff, 4'hf);
		add_write("unmapped write top", 30'h3fff_ffff, 32'd2, 4'hf);
		add_read("gpio output after unmapped writes", 30'd17, {24'h0, b_out});
		add_read("devtbl word 0 after unmapped writes", 30'd0, 32'd7);
		add_read("devtbl word 15 after unmapped writes", 30'd15, 32'd0);
		add_read("gpio input after unmapped writes", 30'd16, {24'h0, b_in});

		c_first = tbl_name.size();
		add_write("warm reset command", 30'd15, 32'd2, 4'h1);
		d_first = tbl_name.size();
		add_read("command word after warm reset", 30'd15, 32'd0);
		add_read("gpio output after warm reset", 30'd17, 32'd0);
		add_read("devtbl word 0 after warm reset", 30'd0, 32'd7);
		e_first = tbl_name.size();
		add_write("power-off command", 30'd15, 32'd1, 4'h1);
		f_first = tbl_name.size();
		add_read("devtbl word 0 after power-off", 30'd0, 32'd7);
		add_read("devtbl word 3 after power-off", 30'd3, 32'd16);
		add_read("gpio output after power-off", 30'd17, 32'd0);

		cycle_limit = 40 * tbl_name.size() + 200;

		repeat (3) @(negedge clk200mhz_w);
		rst_p = 1'b0;
		await_reset_release("rst_p");
		check_value("gp_o after reset", 32'd0, {24'h0, gp_out});
		check_value("data_o idle after reset", 32'd0, rdata);

		// pins settle through two synchronizer flops
		gp_in = b_in;
		apply_entries(a_first, b_first - 1);
		check_value("gp_o after output write", {24'h0, b_out}, {24'h0, gp_out});
		apply_entries(b_first, c_first - 1);
		check_value("sys_rst_o after unmapped writes", 32'd0, {31'h0, sys_rst});
		check_value("gp_o after unmapped writes", {24'h0, b_out}, {24'h0, gp_out});

		apply_entries(c_first, d_first - 1);
		await_reset_rise("warm reset write");
		@(negedge clk200mhz_w);
		check_value("gp_o cleared by warm reset", 32'd0, {24'h0, gp_out});
		await_reset_release("warm reset");
		apply_entries(d_first, e_first - 1);

		apply_entries(e_first, f_first - 1);
		await_reset_rise("power-off write");
		off_ok = 1'b1;
		repeat (40) begin
			@(negedge clk200mhz_w);
			if (!sys_rst)
				off_ok = 1'b0;
		end
		if (!off_ok)
			note_failure("sys_rst_o fell while the system was powered off");
		check_value("gp_o during power-off", 32'd0, {24'h0, gp_out});
		rst_p = 1'b1;
		repeat (3) @(negedge clk200mhz_w);
		rst_p = 1'b0;
		await_reset_release("rst_p after power-off");
		apply_entries(f_first, tbl_name.size() - 1);

		$display("errors: %0d (%0d value mismatches, %0d other failures)",
			mismatches + failures, mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+src
src/soc_bus_pkg.sv
src/soc_ctrl_pkg.sv
src/reset_seq.sv
src/pi1_decoder.sv
src/dev_table.sv
src/gpio_port.sv
src/soc_top.sv
testbench/soc_properties.sv
testbench/tb_soc_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_soc_top
FILELIST  := all.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors
SRCS      := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
